// File: common/l2_bus_pkg.sv
`default_nettype none

package l2_bus_pkg;

    localparam int BUS_W      = 64;            // Beat width in bits
    localparam int BUS_B      = BUS_W / 8;     // Beat width in bytes
    localparam int BUS_ADDR_W = 32;            // Byte address
    localparam int BURST_MAX  = 4;             // Longest INCR burst the bridge issues
    localparam int RESP_W     = 2;

    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

    // Bridge to memory
    typedef struct packed {
        logic                  ar_valid;
        logic [BUS_ADDR_W-1:0] ar_addr;
        logic [7:0]            ar_len;         // Beats minus one
        logic [2:0]            ar_size;        // log2 of bytes per beat
        logic                  aw_valid;
        logic [BUS_ADDR_W-1:0] aw_addr;
        logic [7:0]            aw_len;
        logic [2:0]            aw_size;
        logic                  w_valid;
        logic [BUS_W-1:0]      w_data;
        logic [BUS_B-1:0]      w_strb;
        logic                  w_last;
        logic                  r_ready;
        logic                  b_ready;
    } bus_mosi_t;

    // Memory to bridge
    typedef struct packed {
        logic                  ar_ready;
        logic                  aw_ready;
        logic                  r_valid;
        logic [BUS_W-1:0]      r_data;
        logic [RESP_W-1:0]     r_resp;
        logic                  r_last;
        logic                  w_ready;
        logic                  b_valid;
        logic [RESP_W-1:0]     b_resp;
    } bus_miso_t;

endpackage

`default_nettype wire

// File: common/l2_line_pkg.sv
`default_nettype none

package l2_line_pkg;

    import l2_bus_pkg::*;

    localparam int LINE_W = 256;               // One L2 line
    localparam int LINE_B = LINE_W / 8;
    localparam int ADDR_W = BUS_ADDR_W;        // Same byte address space as the bus

    // Client to bridge, one request held at a time
    typedef struct packed {
        logic              ar_valid;
        logic [ADDR_W-1:0] ar_addr;
        logic [2:0]        ar_size;            // log2 of transfer bytes, 0 to 5
        logic              aw_valid;
        logic [ADDR_W-1:0] aw_addr;
        logic [2:0]        aw_size;
        // Write line travels with aw
        logic [LINE_W-1:0] w_data;
        logic [LINE_B-1:0] w_strb;
        logic              r_ready;
        logic              b_ready;
    } line_req_t;

    // Bridge to client
    typedef struct packed {
        logic              ar_ready;
        logic              aw_ready;
        logic              w_ready;            // Pulses with the last write beat
        logic              r_valid;            // One cycle per read, on the last beat
        logic [LINE_W-1:0] r_data;
        logic [RESP_W-1:0] r_resp;
        logic              b_valid;
        logic [RESP_W-1:0] b_resp;
    } line_rsp_t;

endpackage

`default_nettype wire

// File: serdes/l2_serdes.sv
`timescale 1ns/10ps
`default_nettype none

module l2_serdes import l2_bus_pkg::*, l2_line_pkg::*; (
    input  logic      i_clk,
    input  logic      i_nrst,
    input  line_req_t i_req,
    output line_rsp_t o_rsp,
    output bus_mosi_t o_bus,
    input  bus_miso_t i_bus
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_READ  = 2'd1;
    localparam logic [1:0] ST_WRITE = 2'd2;
    localparam int         CNT_W    = $clog2(BURST_MAX);

    logic [1:0]           state, state_nxt;
    logic [BURST_MAX-1:0] rmux, rmux_nxt;      // One-hot lane for the next read beat
    logic [CNT_W-1:0]     cnt, cnt_nxt;        // Beats left after the current one
    logic                 b_wait, b_wait_nxt;  // Write response owed to the client
    logic [LINE_W-1:0]    line_q, line_nxt;
    logic [LINE_B-1:0]    strb_q, strb_nxt;

    logic                 r_beat;
    logic                 w_beat;
    logic                 burst_end;
    logic                 req_ready;
    logic                 ar_go;
    logic                 aw_go;
    logic [2:0]           req_size;
    logic [7:0]           req_len;
    logic [LINE_W-1:0]    line_rd;

    // Request size to burst len (beats minus one)
    function automatic logic [7:0] size2len(input logic [2:0] size);
        logic [7:0] len;
        case (size)
            3'd4:    len = 8'd1;               // 16 bytes
            3'd5:    len = 8'd3;               // Full line
            default: len = 8'd0;
        endcase
        return len;
    endfunction

    // Bursts always use full beats
    function automatic logic [2:0] size2bus(input logic [2:0] size);
        return (size >= 3'd3) ? 3'd3 : size;
    endfunction

    assign r_beat    = (state == ST_READ) && i_bus.r_valid && i_req.r_ready;
    assign w_beat    = (state == ST_WRITE) && i_bus.w_ready;
    assign burst_end = (cnt == '0);

    // New request allowed when idle or when the last beat goes this cycle
    assign req_ready = (state == ST_IDLE) || ((r_beat || w_beat) && burst_end);

    assign req_size = i_req.ar_valid ? i_req.ar_size : i_req.aw_size;
    assign req_len  = size2len(req_size);

    assign ar_go = req_ready && i_req.ar_valid && i_bus.ar_ready;
    assign aw_go = req_ready && !i_req.ar_valid && i_req.aw_valid && i_bus.aw_ready;

    // Drop the incoming beat into its lane
    always_comb begin
        line_rd = line_q;
        for (int i = 0; i < BURST_MAX; i++) begin
            if (rmux[i]) begin
                line_rd[i*BUS_W +: BUS_W] = i_bus.r_data;
            end
        end
    end

    always_comb begin
        state_nxt  = state;
        rmux_nxt   = rmux;
        cnt_nxt    = cnt;
        b_wait_nxt = b_wait;
        line_nxt   = line_q;
        strb_nxt   = strb_q;

        if (i_bus.b_valid && i_req.b_ready) begin
            b_wait_nxt = 1'b0;
        end

        if (r_beat) begin
            line_nxt = line_rd;
            rmux_nxt = {rmux[BURST_MAX-2:0], 1'b0};
            if (!burst_end) begin
                cnt_nxt = cnt - 1'b1;
            end
        end

        if (w_beat) begin
            // Next beat moves down to lane 0
            line_nxt = {{BUS_W{1'b0}}, line_q[LINE_W-1:BUS_W]};
            strb_nxt = {{BUS_B{1'b0}}, strb_q[LINE_B-1:BUS_B]};
            if (burst_end) begin
                b_wait_nxt = 1'b1;
            end else begin
                cnt_nxt = cnt - 1'b1;
            end
        end

        if (req_ready) begin
            if (ar_go) begin
                state_nxt = ST_READ;
                rmux_nxt  = {{(BURST_MAX-1){1'b0}}, 1'b1};
                cnt_nxt   = req_len[CNT_W-1:0];
            end else if (aw_go) begin
                state_nxt = ST_WRITE;
                line_nxt  = i_req.w_data;
                strb_nxt  = i_req.w_strb;
                cnt_nxt   = req_len[CNT_W-1:0];
            end else begin
                state_nxt = ST_IDLE;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state  <= ST_IDLE;
            rmux   <= '0;
            cnt    <= '0;
            b_wait <= 1'b0;
        end else begin
            state  <= state_nxt;
            rmux   <= rmux_nxt;
            cnt    <= cnt_nxt;
            b_wait <= b_wait_nxt;
        end
    end

    // Line payload
    always_ff @(posedge i_clk) begin
        line_q <= line_nxt;
        strb_q <= strb_nxt;
    end

    always_comb begin
        o_bus.ar_valid = i_req.ar_valid && req_ready;
        o_bus.ar_addr  = i_req.ar_addr;
        o_bus.ar_len   = req_len;
        o_bus.ar_size  = size2bus(req_size);
        o_bus.aw_valid = i_req.aw_valid && !i_req.ar_valid && req_ready;  // Read wins
        o_bus.aw_addr  = i_req.aw_addr;
        o_bus.aw_len   = req_len;
        o_bus.aw_size  = size2bus(req_size);
        o_bus.w_valid  = (state == ST_WRITE);
        o_bus.w_data   = line_q[BUS_W-1:0];
        o_bus.w_strb   = strb_q[BUS_B-1:0];
        o_bus.w_last   = (state == ST_WRITE) && burst_end;
        o_bus.r_ready  = i_req.r_ready;        // Client stalls the beats directly
        o_bus.b_ready  = i_req.b_ready;

        o_rsp.ar_ready = i_bus.ar_ready && req_ready;
        o_rsp.aw_ready = i_bus.aw_ready && req_ready && !i_req.ar_valid;
        o_rsp.w_ready  = w_beat && burst_end;
        o_rsp.r_valid  = r_beat && burst_end;
        o_rsp.r_data   = line_rd;
        o_rsp.r_resp   = i_bus.r_resp;         // Last beat decides
        o_rsp.b_valid  = i_bus.b_valid && b_wait;
        o_rsp.b_resp   = i_bus.b_resp;
    end

endmodule

`default_nettype wire

// File: src/bus_sram.sv
`timescale 1ns/10ps
`default_nettype none

module bus_sram import l2_bus_pkg::*; #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic      i_clk,
    input  logic      i_nrst,
    input  bus_mosi_t i_bus,
    output bus_miso_t o_bus
);

    localparam int IDX_W   = $clog2(MEM_WORDS);
    localparam int BYTE_SH = $clog2(BUS_B);

    logic [BUS_W-1:0] mem [MEM_WORDS];

    logic                  rd_active;
    logic                  wr_active;
    logic                  b_valid;
    logic [RESP_W-1:0]     b_resp;
    logic                  wr_err;             // Sticky across the write burst
    logic [7:0]            cnt;                // Read beats left
    logic [BUS_ADDR_W-1:0] idx;                // Word index of the current beat

    logic idle;
    logic in_range;
    logic ar_go;
    logic aw_go;
    logic r_go;
    logic w_go;

    // One burst at a time, including its write response
    assign idle     = !rd_active && !wr_active && !b_valid;
    assign in_range = (idx < MEM_WORDS);

    assign ar_go = idle && i_bus.ar_valid;
    assign aw_go = idle && !i_bus.ar_valid && i_bus.aw_valid;
    assign r_go  = rd_active && i_bus.r_ready;
    assign w_go  = wr_active && i_bus.w_valid;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rd_active <= 1'b0;
            wr_active <= 1'b0;
            b_valid   <= 1'b0;
            b_resp    <= RESP_OKAY;
            wr_err    <= 1'b0;
            cnt       <= '0;
            idx       <= '0;
        end else begin
            if (ar_go) begin
                rd_active <= 1'b1;
                idx       <= i_bus.ar_addr >> BYTE_SH;
                cnt       <= i_bus.ar_len;
            end else if (aw_go) begin
                wr_active <= 1'b1;
                idx       <= i_bus.aw_addr >> BYTE_SH;
                wr_err    <= 1'b0;
            end
            if (r_go) begin
                if (cnt == '0) begin
                    rd_active <= 1'b0;
                end else begin
                    cnt <= cnt - 1'b1;
                    idx <= idx + 1'b1;
                end
            end
            if (w_go) begin
                idx    <= idx + 1'b1;
                wr_err <= wr_err || !in_range;
                if (i_bus.w_last) begin
                    wr_active <= 1'b0;
                    b_valid   <= 1'b1;
                    b_resp    <= (wr_err || !in_range) ? RESP_SLVERR : RESP_OKAY;
                end
            end
            if (b_valid && i_bus.b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    // Byte merge, out-of-range beats dropped
    always_ff @(posedge i_clk) begin
        if (w_go && in_range) begin
            for (int b = 0; b < BUS_B; b++) begin
                if (i_bus.w_strb[b]) begin
                    mem[idx[IDX_W-1:0]][b*8 +: 8] <= i_bus.w_data[b*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        o_bus.ar_ready = idle;
        o_bus.aw_ready = idle && !i_bus.ar_valid;
        o_bus.r_valid  = rd_active;
        o_bus.r_data   = in_range ? mem[idx[IDX_W-1:0]] : '0;
        o_bus.r_resp   = in_range ? RESP_OKAY : RESP_SLVERR;
        o_bus.r_last   = rd_active && (cnt == '0);
        o_bus.w_ready  = wr_active;
        o_bus.b_valid  = b_valid;
        o_bus.b_resp   = b_resp;
    end

endmodule

`default_nettype wire

// File: src/l2_serdes_top.sv
`timescale 1ns/10ps
`default_nettype none

module l2_serdes_top import l2_bus_pkg::*, l2_line_pkg::*; #(
    parameter int unsigned MEM_WORDS = 256     // Memory depth in beats
) (
    input  logic      i_clk,
    input  logic      i_nrst,
    input  line_req_t i_req,
    output line_rsp_t o_rsp
);

    bus_mosi_t bus_mosi;
    bus_miso_t bus_miso;

    // Line port to burst bus
    l2_serdes serdes_i (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_req  (i_req),
        .o_rsp  (o_rsp),
        .o_bus  (bus_mosi),
        .i_bus  (bus_miso)
    );

    bus_sram #(
        .MEM_WORDS (MEM_WORDS)
    ) sram_i (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_bus  (bus_mosi),
        .o_bus  (bus_miso)
    );

endmodule

`default_nettype wire

// File: dv/l2_serdes_chk.sv
`timescale 1ns/10ps
`default_nettype none

module l2_serdes_chk import l2_bus_pkg::*, l2_line_pkg::*; (
    input logic       i_clk,
    input logic       i_nrst,
    input logic [1:0] i_state,
    input bus_mosi_t  i_mosi,
    input bus_miso_t  i_miso,
    input line_rsp_t  i_rsp
);

    localparam logic [1:0] ST_WRITE = 2'd2;    // Bridge write state encoding

    int fails = 0;

    a_known: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !$isunknown({i_mosi.w_valid, i_rsp.r_valid, i_rsp.b_valid}))
        else begin
            $error("valid signal is X after reset");
            fails++;
        end

    // A write beat may not be withdrawn
    a_w_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_mosi.w_valid && !i_miso.w_ready |=> i_mosi.w_valid)
        else begin
            $error("w_valid dropped before w_ready");
            fails++;
        end

    a_w_last: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_mosi.w_last |-> i_mosi.w_valid)
        else begin
            $error("w_last without w_valid");
            fails++;
        end

    a_no_rd_in_wr: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_state == ST_WRITE) |-> !i_rsp.r_valid)
        else begin
            $error("line r_valid during a write burst");
            fails++;
        end

endmodule

`default_nettype wire

// File: dv/l2_serdes_tb.sv
`timescale 1ns/10ps
`default_nettype none

module l2_serdes_tb import l2_bus_pkg::*, l2_line_pkg::*; ();

    localparam int MEM_WORDS = 256;
    localparam int N_TXN     = 64 + 2 + 8 + 12 + 18 + 9 + 6;  // Prefill, then tests 1 to 6
    localparam int CYC_LIMIT = N_TXN * 16 + 200;

    logic      i_clk  = 1'b0;
    logic      i_nrst = 1'b0;
    line_req_t req;
    line_rsp_t rsp;

    logic [BUS_W-1:0]  model [MEM_WORDS];      // Mirror of the SRAM contents
    logic [31:0]       lfsr   = 32'hbde9_b8cb;
    int                cycles = 0;
    int                errors = 0;
    int                checks = 0;
    int                test_err;
    logic [LINE_W-1:0] rd_data;
    logic [RESP_W-1:0] rd_resp;
    logic [RESP_W-1:0] wr_resp;
    int                r_pulses;
    int                w_pulses;

    l2_serdes_top #(.MEM_WORDS(MEM_WORDS)) dut_i (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_req  (req),
        .o_rsp  (rsp)
    );

    bind l2_serdes l2_serdes_chk chk_i (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_state (state),
        .i_mosi  (o_bus),
        .i_miso  (i_bus),
        .i_rsp   (o_rsp)
    );

    always #2 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYC_LIMIT) begin
            $display("Timeout after %0d cycles, a transaction never completed", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [LINE_W-1:0] rand_line();
        logic [LINE_W-1:0] v;
        for (int i = 0; i < LINE_W / 32; i++) begin
            v[i*32 +: 32] = rand_bits(32);
        end
        return v;
    endfunction

    function automatic int beats_of(input logic [2:0] size);
        return (size == 3'd5) ? 4 : (size == 3'd4) ? 2 : 1;
    endfunction

    task automatic check_line(input logic [LINE_W-1:0] got, input logic [LINE_W-1:0] exp,
                              input logic [LINE_B-1:0] mask, input string what);
        bit bad;
        bad = 0;
        checks++;
        for (int b = 0; b < LINE_B; b++) begin
            if (mask[b] && got[b*8 +: 8] !== exp[b*8 +: 8]) bad = 1;
        end
        if (bad) begin
            errors++;
            $display("FAILED %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input logic [RESP_W-1:0] got, input logic [RESP_W-1:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED %0t: %s, got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [2:0] size,
                               input logic [LINE_W-1:0] data, input logic [LINE_B-1:0] strb,
                               output logic [RESP_W-1:0] resp);
        int w;
        resp = RESP_OKAY;
        for (int k = 0; k < beats_of(size); k++) begin
            w = int'(addr >> 3) + k;
            if (w >= MEM_WORDS) begin
                resp = RESP_SLVERR;            // Beat dropped
            end else begin
                for (int b = 0; b < BUS_B; b++) begin
                    if (strb[k*BUS_B + b]) model[w][b*8 +: 8] = data[k*BUS_W + b*8 +: 8];
                end
            end
        end
    endtask

    // Expected line, byte mask of defined lanes and last-beat response
    task automatic model_read(input logic [ADDR_W-1:0] addr, input logic [2:0] size,
                              output logic [LINE_W-1:0] data, output logic [LINE_B-1:0] mask,
                              output logic [RESP_W-1:0] resp);
        int w;
        data = '0;
        mask = '0;
        for (int k = 0; k < beats_of(size); k++) begin
            w    = int'(addr >> 3) + k;
            resp = (w >= MEM_WORDS) ? RESP_SLVERR : RESP_OKAY;
            if (w < MEM_WORDS) data[k*BUS_W +: BUS_W] = model[w];
            mask[k*BUS_B +: BUS_B] = '1;
        end
    endtask

    task automatic wait_bresp(input int b_delay);
        w_pulses    = 0;
        req.b_ready = (b_delay == 0);
        @(negedge i_clk);
        while (!rsp.b_valid) begin
            if (rsp.w_ready) w_pulses++;       // Last write beat
            @(posedge i_clk);
            #1;
            @(negedge i_clk);
        end
        for (int i = 0; i < b_delay; i++) begin
            @(posedge i_clk);
            #1;
            if (i == b_delay - 1) req.b_ready = 1'b1;
            @(negedge i_clk);
            check_count(int'(rsp.b_valid), 1, "b_valid held while stalled");
        end
        wr_resp = rsp.b_resp;
        @(posedge i_clk);
        #1;
    endtask

    task automatic do_write(input logic [ADDR_W-1:0] addr, input logic [2:0] size,
                            input logic [LINE_W-1:0] data, input logic [LINE_B-1:0] strb,
                            input int b_delay);
        logic [RESP_W-1:0] exp;
        bit                hs;
        model_write(addr, size, data, strb, exp);
        req.aw_valid = 1'b1;
        req.aw_addr  = addr;
        req.aw_size  = size;
        req.w_data   = data;
        req.w_strb   = strb;
        do begin
            @(negedge i_clk);
            hs = rsp.aw_ready;
            @(posedge i_clk);
            #1;
        end while (!hs);
        req.aw_valid = 1'b0;
        wait_bresp(b_delay);
        check_count(w_pulses, 1, "w_ready pulses per write");
        check_resp(wr_resp, exp, "write response");
    endtask

    task automatic do_read(input logic [ADDR_W-1:0] addr, input logic [2:0] size, input bit stall);
        logic [LINE_W-1:0] exp;
        logic [LINE_B-1:0] mask;
        logic [RESP_W-1:0] exp_resp;
        bit                hs;
        model_read(addr, size, exp, mask, exp_resp);
        req.ar_valid = 1'b1;
        req.ar_addr  = addr;
        req.ar_size  = size;
        r_pulses     = 0;
        do begin
            @(negedge i_clk);
            hs = rsp.ar_ready;
            @(posedge i_clk);
            #1;
        end while (!hs);
        req.ar_valid = 1'b0;
        for (int c = 0; c < 40 && r_pulses == 0; c++) begin
            req.r_ready = stall ? 1'(rand_bits(1)) : 1'b1;
            @(negedge i_clk);
            if (rsp.r_valid) begin
                r_pulses++;
                rd_data = rsp.r_data;
                rd_resp = rsp.r_resp;
            end
            @(posedge i_clk);
            #1;
        end
        req.r_ready = 1'b1;
        repeat (2) begin
            @(negedge i_clk);
            if (rsp.r_valid) r_pulses++;       // A second pulse is a fault
            @(posedge i_clk);
            #1;
        end
        check_count(r_pulses, 1, "r_valid pulses per read");
        check_line(rd_data, exp, mask, "read data");
        check_resp(rd_resp, exp_resp, "read response");
    endtask

    task automatic read_then_write(input logic [ADDR_W-1:0] addr);
        logic [LINE_W-1:0] exp;
        logic [LINE_W-1:0] data;
        logic [LINE_B-1:0] mask;
        logic [RESP_W-1:0] exp_resp;
        int                cyc;
        int                ar_cyc;
        int                rd_cyc;
        int                aw_cyc;
        model_read(addr, 3'd5, exp, mask, exp_resp);
        data = rand_line();
        req  = '{ar_valid: 1'b1, ar_addr: addr, ar_size: 3'd5, aw_valid: 1'b1, aw_addr: addr,
                 aw_size: 3'd5, w_data: data, w_strb: '1, r_ready: 1'b1, b_ready: 1'b1};
        cyc    = 0;
        ar_cyc = -1;
        rd_cyc = -1;
        aw_cyc = -1;
        while (rd_cyc < 0 || aw_cyc < 0) begin
            @(negedge i_clk);
            if (req.ar_valid && rsp.ar_ready) ar_cyc = cyc;
            if (req.aw_valid && rsp.aw_ready) aw_cyc = cyc;
            if (rsp.r_valid) begin
                rd_cyc  = cyc;
                rd_data = rsp.r_data;
                rd_resp = rsp.r_resp;
            end
            @(posedge i_clk);
            #1;
            if (ar_cyc >= 0) req.ar_valid = 1'b0;
            if (aw_cyc >= 0) req.aw_valid = 1'b0;
            cyc++;
        end
        check_count(int'(aw_cyc >= rd_cyc), 1, "write accepted after the read");
        check_line(rd_data, exp, mask, "read before write sees old data");
        check_resp(rd_resp, exp_resp, "read response");
        model_write(addr, 3'd5, data, '1, exp_resp);
        wait_bresp(0);
        check_resp(wr_resp, exp_resp, "write response");
    endtask

    task automatic report(input string name);
        $display("%-14s %s (%0d errors)", name, (errors == test_err) ? "ok" : "failed",
                 errors - test_err);
        test_err = errors;
    endtask

    initial begin
        logic [ADDR_W-1:0] addr;
        req         = '0;
        req.r_ready = 1'b1;
        req.b_ready = 1'b1;
        test_err    = 0;
        repeat (10) @(posedge i_clk);
        #1 i_nrst = 1'b1;

        for (int l = 0; l < MEM_WORDS / 4; l++) do_write(l * 32, 3'd5, rand_line(), '1, 0);
        report("prefill");

        addr = rand_bits(6) * 32;
        do_write(addr, 3'd5, rand_line(), '1, 0);
        do_read(addr, 3'd5, 0);
        report("full line");

        repeat (4) begin
            addr = rand_bits(6) * 32;
            do_write(addr, 3'd5, rand_line(), rand_bits(32), 0);
            do_read(addr, 3'd5, 0);
        end
        report("partial strb");

        repeat (12) begin
            addr = rand_bits(7) * 16;          // Word index stays below 255
            do_read(addr, 3'(rand_bits(3) % 5), 0);
        end
        report("short sizes");

        repeat (6) begin
            addr = rand_bits(6) * 32;
            do_write(addr, 3'd5, rand_line(), rand_bits(32), 1 + rand_bits(2));
            do_read(addr, 3'd5, 1);
            do_read(rand_bits(7) * 16, 3'd4, 1);
        end
        report("back-pressure");

        repeat (3) begin
            addr = rand_bits(6) * 32;
            do_write(addr + MEM_WORDS * 8, 3'd5, rand_line(), '1, 0);
            do_read(addr + MEM_WORDS * 8, 3'd5, 0);
            do_read(addr, 3'd5, 0);            // Aliased word left untouched
        end
        report("out of range");

        repeat (2) begin
            addr = rand_bits(6) * 32;
            read_then_write(addr);
            do_read(addr, 3'd5, 0);
        end
        report("read priority");

        errors += dut_i.serdes_i.chk_i.fails;
        $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: l2_serdes.f
common/l2_bus_pkg.sv
common/l2_line_pkg.sv
serdes/l2_serdes.sv
src/bus_sram.sv
src/l2_serdes_top.sv
dv/l2_serdes_chk.sv
dv/l2_serdes_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= l2_serdes_tb
FILELIST  ?= l2_serdes.f
LOG       ?= sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
